//--- source/dma_cfg.svh
////////////////////////////////////////
// DMA request path configuration
// Table size and packet size are fixed here
// Field ranges assume a 34-bit flit
// Register map uses a 16-byte stride per entry
////////////////////////////////////////
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

`define DMA_TABLE_ENTRIES 4
`define DMA_PACKET_SIZE   16
`define DMA_TILE_ID       3
`define DMA_FLIT_WIDTH    34
`define DMA_DATA_WIDTH    32

// Flit field ranges
`define DMA_FLIT_TYPE     33:32
`define DMA_FLIT_DEST     31:27
`define DMA_FLIT_CLASS    26:24
`define DMA_FLIT_SRC      23:19
`define DMA_FLIT_PTYPE    18:17
`define DMA_FLIT_LASTPKT  16
`define DMA_FLIT_ID       15:12
`define DMA_FLIT_SIZE     11:0
`define DMA_FLIT_CONTENT  31:0

// Flit type, class and packet type codes
`define DMA_TYPE_PAYLOAD  2'b00
`define DMA_TYPE_HEADER   2'b01
`define DMA_TYPE_LAST     2'b10
`define DMA_CLASS_DMA     3'd2
`define DMA_PTYPE_L2R     2'b00
`define DMA_PTYPE_R2L     2'b01

// APB register map, offsets within one entry
`define DMA_REG_STRIDE    16
`define DMA_REG_LADDR     4'h0
`define DMA_REG_RADDR     4'h4
`define DMA_REG_CTRL      4'h8
`define DMA_REG_STATUS    4'hc

// Control register fields
`define DMA_CTRL_DIR      31
`define DMA_CTRL_RTILE    20:16
`define DMA_CTRL_SIZE     11:0

`endif

//--- source/dma_pkg.sv
////////////////////////////////////////
// Shared types of the DMA request path
// Widths follow the config header
////////////////////////////////////////
`default_nettype none

package dma_pkg;

  `include "dma_cfg.svh"

  // NoC flit and bus words
  typedef logic [`DMA_FLIT_WIDTH-1:0] flit_t;
  typedef logic [31:0]                addr_t;
  typedef logic [`DMA_DATA_WIDTH-1:0] data_t;

  // Descriptor fields
  typedef logic [11:0] size_t;
  typedef logic [4:0]  tile_t;

  // Table index and per-entry masks
  typedef logic [$clog2(`DMA_TABLE_ENTRIES)-1:0] entry_idx_t;
  typedef logic [`DMA_TABLE_ENTRIES-1:0]         entry_mask_t;

  // Packet generator states
  typedef enum logic [2:0] {
    GEN_IDLE,
    GEN_L2R_HDR,
    GEN_L2R_ADDR,
    GEN_L2R_DATA,
    GEN_R2L_HDR,
    GEN_R2L_SIZE,
    GEN_R2L_RADDR,
    GEN_R2L_LADDR
  } gen_state_t;

endpackage

`default_nettype wire

//--- source/dma_req_table.sv
////////////////////////////////////////
// Descriptor table behind an APB slave
// pready is tied high, no wait states
// Registers of a valid entry are locked
// Status write of 1 sets valid, done clears it
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_req_table (
  input  logic                clk,
  input  logic                rst,
  // APB register port
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  dma_pkg::addr_t      paddr,
  input  dma_pkg::data_t      pwdata,
  output dma_pkg::data_t      prdata,
  output logic                pready,
  output logic                pslverr,
  // Completion from the response path
  input  logic                done_en,
  input  dma_pkg::entry_idx_t done_pos,
  // Read port toward the generator
  input  dma_pkg::entry_idx_t read_pos,
  output dma_pkg::entry_mask_t valid,
  output dma_pkg::addr_t      rd_laddr,
  output dma_pkg::addr_t      rd_raddr,
  output dma_pkg::tile_t      rd_rtile,
  output dma_pkg::size_t      rd_size,
  output logic                rd_is_l2r
);

  import dma_pkg::*;

  // Descriptor storage
  addr_t laddr_q [`DMA_TABLE_ENTRIES];
  addr_t raddr_q [`DMA_TABLE_ENTRIES];
  tile_t rtile_q [`DMA_TABLE_ENTRIES];
  size_t size_q  [`DMA_TABLE_ENTRIES];
  logic  l2r_q   [`DMA_TABLE_ENTRIES];

  entry_idx_t apb_pos;
  logic [3:0] apb_off;
  logic       in_range;
  logic       wr_en;

  ////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////
  assign apb_pos  = entry_idx_t'(paddr / `DMA_REG_STRIDE);
  assign apb_off  = 4'(paddr % `DMA_REG_STRIDE);
  assign in_range = paddr < addr_t'(`DMA_TABLE_ENTRIES * `DMA_REG_STRIDE);
  assign wr_en    = psel & penable & pwrite & in_range;

  // Every access completes in its access phase
  assign pready  = 1'b1;
  assign pslverr = psel & penable & ~in_range;

  // Descriptor writes, only while the entry is free
  always_ff @(posedge clk) begin
    if (wr_en && !valid[apb_pos]) begin
      case (apb_off)
        `DMA_REG_LADDR: laddr_q[apb_pos] <= pwdata;
        `DMA_REG_RADDR: raddr_q[apb_pos] <= pwdata;
        `DMA_REG_CTRL: begin
          l2r_q[apb_pos]   <= pwdata[`DMA_CTRL_DIR];
          rtile_q[apb_pos] <= pwdata[`DMA_CTRL_RTILE];
          size_q[apb_pos]  <= pwdata[`DMA_CTRL_SIZE];
        end
        default: ;
      endcase
    end
  end

  // Valid bits, a start in the same cycle as done wins
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else begin
      if (done_en) begin
        valid[done_pos] <= 1'b0;
      end
      if (wr_en && apb_off == `DMA_REG_STATUS && pwdata[0]) begin
        valid[apb_pos] <= 1'b1;
      end
    end
  end

  // Readback mux, unmapped offsets read zero
  always_comb begin
    prdata = '0;
    if (in_range) begin
      case (apb_off)
        `DMA_REG_LADDR: prdata = laddr_q[apb_pos];
        `DMA_REG_RADDR: prdata = raddr_q[apb_pos];
        `DMA_REG_CTRL: begin
          prdata[`DMA_CTRL_DIR]   = l2r_q[apb_pos];
          prdata[`DMA_CTRL_RTILE] = rtile_q[apb_pos];
          prdata[`DMA_CTRL_SIZE]  = size_q[apb_pos];
        end
        `DMA_REG_STATUS: prdata[0] = valid[apb_pos];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Generator read port
  ////////////////////////////////////////
  assign rd_laddr  = laddr_q[read_pos];
  assign rd_raddr  = raddr_q[read_pos];
  assign rd_rtile  = rtile_q[read_pos];
  assign rd_size   = size_q[read_pos];
  assign rd_is_l2r = l2r_q[read_pos];

endmodule

`default_nettype wire

//--- source/dma_noc_req_gen.sv
////////////////////////////////////////
// Request packet generator
// Round-robin over valid, unissued entries
// R2L goes out as one four-flit packet
// L2R is split into packets of up to 14 words
// L2R size must be nonzero
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_noc_req_gen (
  input  logic                 clk,
  input  logic                 rst,
  // Descriptor table
  input  dma_pkg::entry_mask_t valid,
  output dma_pkg::entry_idx_t  read_pos,
  input  dma_pkg::addr_t       rd_laddr,
  input  dma_pkg::addr_t       rd_raddr,
  input  dma_pkg::tile_t       rd_rtile,
  input  dma_pkg::size_t       rd_size,
  input  logic                 rd_is_l2r,
  // Local reader
  output logic                 start,
  output dma_pkg::addr_t       start_laddr,
  output dma_pkg::size_t       start_size,
  input  logic                 word_valid,
  input  dma_pkg::data_t       word_data,
  output logic                 word_ready,
  // Output stage
  output logic                 gen_valid,
  output dma_pkg::flit_t       gen_flit,
  input  logic                 gen_ready
);

  import dma_pkg::*;

  // Payload words per L2R packet, header and address take two flits
  localparam size_t MAX_WORDS = size_t'(`DMA_PACKET_SIZE - 2);

  gen_state_t  state;
  logic        grant_vld;
  entry_idx_t  rr_ptr;
  entry_mask_t issued;
  entry_mask_t req;
  entry_idx_t  pick;
  logic        pick_hit;

  // L2R progress
  size_t sent;
  size_t pkt_len;
  size_t pkt_cnt;
  size_t remain;
  size_t pkt_words;
  logic  last_pkt;
  logic  last_word;
  logic  xfer;
  flit_t hdr_base;

  ////////////////////////////////////////
  // Entry selection
  ////////////////////////////////////////
  assign req = valid & ~issued;

  // First requester at or after the pointer
  always_comb begin
    pick     = rr_ptr;
    pick_hit = 1'b0;
    for (int i = 0; i < `DMA_TABLE_ENTRIES; i++) begin
      if (!pick_hit && req[entry_idx_t'(rr_ptr + i)]) begin
        pick     = entry_idx_t'(rr_ptr + i);
        pick_hit = 1'b1;
      end
    end
  end

  // Reader takes the descriptor of the granted entry
  assign start_laddr = rd_laddr;
  assign start_size  = rd_size;

  // Packet split of the remaining L2R words
  assign remain    = rd_size - sent;
  assign last_pkt  = remain <= MAX_WORDS;
  assign pkt_words = last_pkt ? remain : MAX_WORDS;
  assign last_word = pkt_cnt == pkt_len - size_t'(1);
  assign xfer      = gen_valid & gen_ready;

  // Header fields common to both directions
  always_comb begin
    hdr_base                   = '0;
    hdr_base[`DMA_FLIT_TYPE]   = `DMA_TYPE_HEADER;
    hdr_base[`DMA_FLIT_DEST]   = rd_rtile;
    hdr_base[`DMA_FLIT_CLASS]  = `DMA_CLASS_DMA;
    hdr_base[`DMA_FLIT_SRC]    = tile_t'(`DMA_TILE_ID);
    hdr_base[`DMA_FLIT_ID]     = 4'(read_pos);
  end

  ////////////////////////////////////////
  // Flit output per state
  ////////////////////////////////////////
  always_comb begin
    gen_valid  = 1'b0;
    gen_flit   = '0;
    word_ready = 1'b0;
    case (state)
      GEN_L2R_HDR: begin
        gen_valid                    = 1'b1;
        gen_flit                     = hdr_base;
        gen_flit[`DMA_FLIT_PTYPE]    = `DMA_PTYPE_L2R;
        gen_flit[`DMA_FLIT_LASTPKT]  = last_pkt;
        gen_flit[`DMA_FLIT_SIZE]     = pkt_words;
      end
      GEN_L2R_ADDR: begin
        // Remote address advances by the words already sent
        gen_valid                    = 1'b1;
        gen_flit[`DMA_FLIT_TYPE]     = `DMA_TYPE_PAYLOAD;
        gen_flit[`DMA_FLIT_CONTENT]  = rd_raddr + addr_t'({sent, 2'b00});
      end
      GEN_L2R_DATA: begin
        // Word queue holds its head until popped
        gen_valid                    = word_valid;
        word_ready                   = gen_ready;
        gen_flit[`DMA_FLIT_TYPE]     = last_word ? `DMA_TYPE_LAST : `DMA_TYPE_PAYLOAD;
        gen_flit[`DMA_FLIT_CONTENT]  = word_data;
      end
      GEN_R2L_HDR: begin
        gen_valid                    = 1'b1;
        gen_flit                     = hdr_base;
        gen_flit[`DMA_FLIT_PTYPE]    = `DMA_PTYPE_R2L;
        gen_flit[`DMA_FLIT_LASTPKT]  = 1'b1;
      end
      GEN_R2L_SIZE: begin
        gen_valid                    = 1'b1;
        gen_flit[`DMA_FLIT_TYPE]     = `DMA_TYPE_PAYLOAD;
        gen_flit[`DMA_FLIT_SIZE]     = rd_size;
      end
      GEN_R2L_RADDR: begin
        gen_valid                    = 1'b1;
        gen_flit[`DMA_FLIT_TYPE]     = `DMA_TYPE_PAYLOAD;
        gen_flit[`DMA_FLIT_CONTENT]  = rd_raddr;
      end
      GEN_R2L_LADDR: begin
        gen_valid                    = 1'b1;
        gen_flit[`DMA_FLIT_TYPE]     = `DMA_TYPE_LAST;
        gen_flit[`DMA_FLIT_CONTENT]  = rd_laddr;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // State and counters
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= GEN_IDLE;
      grant_vld <= 1'b0;
      read_pos  <= '0;
      rr_ptr    <= '0;
      issued    <= '0;
      start     <= 1'b0;
      sent      <= '0;
      pkt_len   <= '0;
      pkt_cnt   <= '0;
    end else begin
      start <= 1'b0;
      // Forget issued entries once the table drops them
      issued <= issued & valid;
      case (state)
        GEN_IDLE: begin
          if (grant_vld) begin
            grant_vld <= 1'b0;
            rr_ptr    <= read_pos + entry_idx_t'(1);
            issued    <= (issued | (entry_mask_t'(1) << read_pos)) & valid;
            sent      <= '0;
            // Reader only fetches for L2R
            start     <= rd_is_l2r;
            state     <= rd_is_l2r ? GEN_L2R_HDR : GEN_R2L_HDR;
          end else if (pick_hit) begin
            grant_vld <= 1'b1;
            read_pos  <= pick;
          end
        end
        GEN_L2R_HDR: begin
          if (xfer) begin
            pkt_len <= pkt_words;
            pkt_cnt <= '0;
            state   <= GEN_L2R_ADDR;
          end
        end
        GEN_L2R_ADDR: begin
          if (xfer) begin
            state <= GEN_L2R_DATA;
          end
        end
        GEN_L2R_DATA: begin
          if (xfer) begin
            pkt_cnt <= pkt_cnt + size_t'(1);
            if (last_word) begin
              sent  <= sent + pkt_len;
              state <= (sent + pkt_len == rd_size) ? GEN_IDLE : GEN_L2R_HDR;
            end
          end
        end
        GEN_R2L_HDR: begin
          if (xfer) state <= GEN_R2L_SIZE;
        end
        GEN_R2L_SIZE: begin
          if (xfer) state <= GEN_R2L_RADDR;
        end
        GEN_R2L_RADDR: begin
          if (xfer) state <= GEN_R2L_LADDR;
        end
        GEN_R2L_LADDR: begin
          if (xfer) state <= GEN_IDLE;
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/dma_local_reader.sv
////////////////////////////////////////
// L2R payload reader from tile memory
// Memory answers one cycle after mem_en
// mem_addr is a byte address, steps of 4
// start is only accepted while idle
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_local_reader (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  dma_pkg::addr_t start_laddr,
  input  dma_pkg::size_t start_size,
  // Tile memory
  output logic           mem_en,
  output dma_pkg::addr_t mem_addr,
  input  dma_pkg::data_t mem_rdata,
  // Word queue toward the generator
  output logic           word_valid,
  output dma_pkg::data_t word_data,
  input  logic           word_ready
);

  import dma_pkg::*;

  addr_t      addr_q;
  size_t      left_q;
  logic       pending_q;
  data_t      queue_q [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count_q;
  logic [1:0] occ;
  logic       pop;

  assign pop = word_valid & word_ready;

  // Queued words plus the one in flight, after this cycle's pop
  assign occ = count_q + 2'(pending_q) - 2'(pop);

  // Fetch only with room for the returning word
  assign mem_en   = (left_q != '0) && (occ < 2'd2);
  assign mem_addr = addr_q;

  assign word_valid = count_q != 2'd0;
  assign word_data  = queue_q[rd_ptr];

  // Fetch control
  always_ff @(posedge clk) begin
    if (rst) begin
      left_q    <= '0;
      pending_q <= 1'b0;
      count_q   <= '0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
    end else begin
      pending_q <= mem_en;
      count_q   <= occ;
      if (start) begin
        left_q <= start_size;
      end else if (mem_en) begin
        left_q <= left_q - size_t'(1);
      end
      // Read data lands in the queue the cycle after the fetch
      if (pending_q) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
    end
  end

  // Address and queue storage
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= start_laddr;
    end else if (mem_en) begin
      addr_q <= addr_q + addr_t'(4);
    end
    if (pending_q) begin
      queue_q[wr_ptr] <= mem_rdata;
    end
  end

endmodule

`default_nettype wire

//--- source/dma_flit_out.sv
////////////////////////////////////////
// Output skid buffer toward the router
// NoC side driven straight from registers
// Holds two flits before gen_ready drops
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_flit_out (
  input  logic           clk,
  input  logic           rst,
  input  logic           gen_valid,
  input  dma_pkg::flit_t gen_flit,
  output logic           gen_ready,
  output logic           noc_valid,
  output dma_pkg::flit_t noc_flit,
  input  logic           noc_ready
);

  import dma_pkg::*;

  flit_t skid_flit;
  logic  skid_vld;
  logic  push;
  logic  out_free;

  // Accept while the skid slot is empty
  assign gen_ready = ~skid_vld;
  assign push      = gen_valid & gen_ready;
  // Output slot empties this cycle
  assign out_free  = ~noc_valid | noc_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      noc_valid <= 1'b0;
      skid_vld  <= 1'b0;
    end else if (out_free) begin
      // Skid entry is older, drain it first
      noc_valid <= skid_vld | push;
      skid_vld  <= 1'b0;
    end else if (push) begin
      skid_vld  <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      noc_flit <= skid_vld ? skid_flit : gen_flit;
    end else if (push) begin
      skid_flit <= gen_flit;
    end
  end

endmodule

`default_nettype wire

//--- source/dma_noc_req_top.sv
////////////////////////////////////////
// DMA request path of one NoC tile
// APB table, generator, reader, output stage
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_noc_req_top (
  input  logic                clk,
  input  logic                rst,
  // APB register port
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  dma_pkg::addr_t      paddr,
  input  dma_pkg::data_t      pwdata,
  output dma_pkg::data_t      prdata,
  output logic                pready,
  output logic                pslverr,
  // Completion from the response path
  input  logic                done_en,
  input  dma_pkg::entry_idx_t done_pos,
  // Tile memory
  output logic                mem_en,
  output dma_pkg::addr_t      mem_addr,
  input  dma_pkg::data_t      mem_rdata,
  // NoC port
  output logic                noc_valid,
  output dma_pkg::flit_t      noc_flit,
  input  logic                noc_ready
);

  import dma_pkg::*;

  // Table read port
  entry_mask_t valid;
  entry_idx_t  read_pos;
  addr_t       rd_laddr;
  addr_t       rd_raddr;
  tile_t       rd_rtile;
  size_t       rd_size;
  logic        rd_is_l2r;

  // Reader handshake
  logic        start;
  addr_t       start_laddr;
  size_t       start_size;
  logic        word_valid;
  data_t       word_data;
  logic        word_ready;

  // Generator to output stage
  logic        gen_valid;
  flit_t       gen_flit;
  logic        gen_ready;

  // Port names match the wires above
  dma_req_table dma_req_table_i (.*);

  dma_noc_req_gen dma_noc_req_gen_i (.*);

  dma_local_reader dma_local_reader_i (.*);

  dma_flit_out dma_flit_out_i (.*);

endmodule

`default_nettype wire

//--- dv/dma_noc_req_assert.sv
////////////////////////////////////////
// Handshake and reset assertions
// Bound into the DMA request top level
// Reset checks assume a synchronous reset
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_noc_req_assert (
  input logic           clk,
  input logic           rst,
  input logic           noc_valid,
  input dma_pkg::flit_t noc_flit,
  input logic           noc_ready,
  input logic           mem_en,
  input logic           pready
);

  // Stalled flit holds until the router takes it
  noc_hold: assert property (@(posedge clk) disable iff (rst)
    noc_valid && !noc_ready |=> noc_valid && $stable(noc_flit))
    else $error("noc_valid or noc_flit changed while stalled");

  // No NoC or memory request out of reset
  reset_idle: assert property (@(posedge clk) rst |=> !noc_valid && !mem_en)
    else $error("noc_valid or mem_en high after a reset edge");

  // APB has no wait states
  pready_high: assert property (@(posedge clk) pready)
    else $error("pready dropped");

endmodule

bind dma_noc_req_top dma_noc_req_assert dma_noc_req_assert_i (
  .clk       (clk),
  .rst       (rst),
  .noc_valid (noc_valid),
  .noc_flit  (noc_flit),
  .noc_ready (noc_ready),
  .mem_en    (mem_en),
  .pready    (pready)
);

`default_nettype wire

//--- dv/dma_noc_req_tb.sv
////////////////////////////////////////
// Testbench for the DMA request path
// APB, done and noc_ready change on the falling edge
// Memory returns word address ^ 32'h5a5a0000
// Expected flits come from a descriptor table
// Back-pressure from $random with a fixed seed
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_noc_req_tb;

  import dma_pkg::*;

  localparam int HALF          = 20;
  localparam int NUM_ROWS      = 7;
  localparam int WORDS_PER_PKT = `DMA_PACKET_SIZE - 2;

  // One descriptor of the stimulus table
  typedef struct packed {
    entry_idx_t entry;
    logic       l2r;
    tile_t      rtile;
    addr_t      laddr;
    addr_t      raddr;
    size_t      size;
    logic       rand_ready;
    logic       batch_end;
  } row_t;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  addr_t       paddr;
  data_t       pwdata;
  data_t       prdata;
  logic        pready;
  logic        pslverr;
  logic        done_en;
  entry_idx_t  done_pos;
  logic        mem_en;
  addr_t       mem_addr;
  data_t       mem_rdata = '0;
  logic        noc_valid;
  flit_t       noc_flit;
  logic        noc_ready = 1'b1;

  row_t   rows [NUM_ROWS];
  flit_t  exp_q [$];
  logic   bp_on = 1'b0;
  integer seed = 32'h9e2f6bf8;
  integer rnd;
  int     cycle_count = 0;
  int     cycle_limit = 1000000;
  logic   rd_pend = 1'b0;
  addr_t  rd_addr;

  dma_noc_req_top dma_noc_req_top_i (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .done_en   (done_en),
    .done_pos  (done_pos),
    .mem_en    (mem_en),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .noc_valid (noc_valid),
    .noc_flit  (noc_flit),
    .noc_ready (noc_ready)
  );

  always #(HALF) clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic data_t mem_word(input addr_t a);
    return (a >> 2) ^ 32'h5a5a0000;
  endfunction

  function automatic flit_t make_header(input tile_t dest, input logic [1:0] ptype,
                                        input logic last, input entry_idx_t id,
                                        input size_t size);
    flit_t f;
    f                    = '0;
    f[`DMA_FLIT_TYPE]    = `DMA_TYPE_HEADER;
    f[`DMA_FLIT_DEST]    = dest;
    f[`DMA_FLIT_CLASS]   = `DMA_CLASS_DMA;
    f[`DMA_FLIT_SRC]     = tile_t'(`DMA_TILE_ID);
    f[`DMA_FLIT_PTYPE]   = ptype;
    f[`DMA_FLIT_LASTPKT] = last;
    f[`DMA_FLIT_ID]      = 4'(id);
    f[`DMA_FLIT_SIZE]    = size;
    return f;
  endfunction

  function automatic flit_t make_word(input logic [1:0] ftype, input data_t d);
    return {ftype, d};
  endfunction

  function automatic int flit_count(input row_t r);
    int pkts;
    pkts = (int'(r.size) + WORDS_PER_PKT - 1) / WORDS_PER_PKT;
    return r.l2r ? 2 * pkts + int'(r.size) : 4;
  endfunction

  function automatic addr_t reg_addr(input entry_idx_t e, input logic [3:0] off);
    return addr_t'(e) * addr_t'(`DMA_REG_STRIDE) + addr_t'(off);
  endfunction

  function automatic data_t make_ctrl(input row_t r);
    data_t c;
    c                  = '0;
    c[`DMA_CTRL_DIR]   = r.l2r;
    c[`DMA_CTRL_RTILE] = r.rtile;
    c[`DMA_CTRL_SIZE]  = r.size;
    return c;
  endfunction

  // Flits one descriptor must produce, in order
  task automatic push_expected(input row_t r);
    int    sent;
    int    n;
    int    k;
    addr_t wa;
    if (!r.l2r) begin
      exp_q.push_back(make_header(r.rtile, `DMA_PTYPE_R2L, 1'b1, r.entry, '0));
      exp_q.push_back(make_word(`DMA_TYPE_PAYLOAD, data_t'(r.size)));
      exp_q.push_back(make_word(`DMA_TYPE_PAYLOAD, r.raddr));
      exp_q.push_back(make_word(`DMA_TYPE_LAST, r.laddr));
    end else begin
      sent = 0;
      while (sent < int'(r.size)) begin
        n = (int'(r.size) - sent > WORDS_PER_PKT) ? WORDS_PER_PKT : int'(r.size) - sent;
        exp_q.push_back(make_header(r.rtile, `DMA_PTYPE_L2R, sent + n == int'(r.size),
                                    r.entry, size_t'(n)));
        exp_q.push_back(make_word(`DMA_TYPE_PAYLOAD, r.raddr + addr_t'(4 * sent)));
        for (k = 0; k < n; k++) begin
          wa = r.laddr + addr_t'(4 * (sent + k));
          exp_q.push_back(make_word(k == n - 1 ? `DMA_TYPE_LAST : `DMA_TYPE_PAYLOAD,
                                    mem_word(wa)));
        end
        sent += n;
      end
    end
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic end_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
      $display("ERROR: %s got %h expected %h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("ERROR: %s got %h expected %h", name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_slverr(input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR: pslverr got %h expected %h", got, exp);
      end_with_failure();
    end
  endtask

  ////////////////////////////////////////
  // APB and done drivers
  ////////////////////////////////////////
  task automatic apb_access(input logic wr, input addr_t addr, input data_t wdata,
                            output data_t rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    // Mid access phase, well clear of both edges
    #(HALF / 2);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input addr_t addr, input data_t data);
    data_t rd;
    logic  err;
    apb_access(1'b1, addr, data, rd, err);
    check_slverr(err, 1'b0);
  endtask

  task automatic read_check(input addr_t addr, input data_t exp);
    data_t rd;
    logic  err;
    apb_access(1'b0, addr, '0, rd, err);
    check_slverr(err, 1'b0);
    check_data("prdata", rd, exp);
  endtask

  task automatic program_entry(input row_t r);
    write_reg(reg_addr(r.entry, `DMA_REG_LADDR), r.laddr);
    write_reg(reg_addr(r.entry, `DMA_REG_RADDR), r.raddr);
    write_reg(reg_addr(r.entry, `DMA_REG_CTRL), make_ctrl(r));
  endtask

  task automatic check_entry_regs(input row_t r);
    read_check(reg_addr(r.entry, `DMA_REG_LADDR), r.laddr);
    read_check(reg_addr(r.entry, `DMA_REG_RADDR), r.raddr);
    read_check(reg_addr(r.entry, `DMA_REG_CTRL), make_ctrl(r));
  endtask

  task automatic pulse_done(input entry_idx_t e);
    @(negedge clk);
    done_en  = 1'b1;
    done_pos = e;
    @(negedge clk);
    done_en  = 1'b0;
  endtask

  task automatic wait_flits();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // Register map and entry lock
  ////////////////////////////////////////
  task automatic check_registers();
    row_t  regs [4];
    row_t  bad;
    data_t rd;
    logic  err;
    int    e;
    for (e = 0; e < 4; e++) begin
      regs[e]            = '0;
      regs[e].entry      = entry_idx_t'(e);
      regs[e].rtile      = tile_t'(e + 20);
      regs[e].laddr      = addr_t'(32'h1000_0040 + 32'h100 * e);
      regs[e].raddr      = addr_t'(32'h2000_0000 + 32'h10 * e);
      regs[e].size       = size_t'(e * 100 + 7);
      program_entry(regs[e]);
    end
    for (e = 0; e < 4; e++) begin
      check_entry_regs(regs[e]);
      read_check(reg_addr(regs[e].entry, `DMA_REG_STATUS), '0);
    end
    // Past the last entry, a status write here must not start anything
    apb_access(1'b1, 32'h0000_004c, 32'h1, rd, err);
    check_slverr(err, 1'b1);
    apb_access(1'b0, 32'h0000_007c, '0, rd, err);
    check_slverr(err, 1'b1);
    // Entry 3 goes valid and sends one R2L packet
    push_expected(regs[3]);
    write_reg(reg_addr(2'd3, `DMA_REG_STATUS), data_t'(1));
    read_check(reg_addr(2'd3, `DMA_REG_STATUS), data_t'(1));
    bad       = regs[3];
    bad.l2r   = 1'b1;
    bad.rtile = ~regs[3].rtile;
    bad.laddr = ~regs[3].laddr;
    bad.raddr = ~regs[3].raddr;
    bad.size  = ~regs[3].size;
    program_entry(bad);
    check_entry_regs(regs[3]);
    wait_flits();
    pulse_done(2'd3);
    read_check(reg_addr(2'd3, `DMA_REG_STATUS), '0);
  endtask

  ////////////////////////////////////////
  // Descriptor table, batch by batch
  ////////////////////////////////////////
  task automatic run_rows();
    int i;
    int b;
    int first;
    first = 0;
    for (i = 0; i < NUM_ROWS; i++) begin
      program_entry(rows[i]);
      if (rows[i].batch_end) begin
        bp_on = 1'b0;
        for (b = first; b <= i; b++) begin
          bp_on = bp_on | rows[b].rand_ready;
        end
        // Start in table order, flits must follow in that order
        for (b = first; b <= i; b++) begin
          push_expected(rows[b]);
          write_reg(reg_addr(rows[b].entry, `DMA_REG_STATUS), data_t'(1));
        end
        wait_flits();
        bp_on = 1'b0;
        // Quiet window, issued entries must not be sent again
        repeat (24) @(negedge clk);
        for (b = first; b <= i; b++) begin
          read_check(reg_addr(rows[b].entry, `DMA_REG_STATUS), data_t'(1));
          pulse_done(rows[b].entry);
          read_check(reg_addr(rows[b].entry, `DMA_REG_STATUS), '0);
        end
        first = i + 1;
      end
    end
  endtask

  ////////////////////////////////////////
  // Memory model and NoC monitor
  ////////////////////////////////////////
  // Word for a fetch seen in the previous cycle
  always @(negedge clk) begin
    if (rd_pend) mem_rdata = mem_word(rd_addr);
    rd_pend = mem_en;
    rd_addr = mem_addr;
  end

  // noc_ready first, then the transfer at the coming rising edge
  always @(negedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, %0d flits never arrived", cycle_count,
               exp_q.size());
      end_with_failure();
    end else begin
      rnd = $random(seed);
      noc_ready = bp_on ? rnd[0] : 1'b1;
      if (noc_valid === 1'b1 && noc_ready) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected flit %h on the NoC port", noc_flit);
          end_with_failure();
        end else begin
          check_flit("noc_flit", noc_flit, exp_q.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    done_en  = 1'b0;
    done_pos = '0;

    // entry, l2r, tile, laddr, raddr, size, random ready, batch end
    rows[0] = '{2'd0, 1'b0, 5'd5,  32'h1000_0040, 32'h2000_0100, 12'd9,   1'b0, 1'b1};
    rows[1] = '{2'd1, 1'b1, 5'd12, 32'h0000_0400, 32'h8000_0000, 12'd30,  1'b0, 1'b1};
    rows[2] = '{2'd1, 1'b1, 5'd12, 32'h0000_0400, 32'h8000_0000, 12'd30,  1'b1, 1'b1};
    rows[3] = '{2'd0, 1'b0, 5'd5,  32'h1000_0040, 32'h2000_0100, 12'd9,   1'b1, 1'b1};
    rows[4] = '{2'd0, 1'b0, 5'd7,  32'h0000_1230, 32'h0abc_0000, 12'd4,   1'b0, 1'b0};
    rows[5] = '{2'd1, 1'b1, 5'd9,  32'h0000_0800, 32'h4000_0010, 12'd3,   1'b0, 1'b0};
    rows[6] = '{2'd2, 1'b0, 5'd31, 32'h0000_2000, 32'hffff_fff0, 12'h7ff, 1'b1, 1'b1};

    // Four flits of the register test plus the table
    cycle_limit = 4;
    for (int i = 0; i < NUM_ROWS; i++) begin
      cycle_limit += flit_count(rows[i]);
    end
    cycle_limit = 40 * cycle_limit + 200;

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_registers();
    run_rows();
    repeat (4) @(negedge clk);

    if (exp_q.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("Run ended with %0d flits still expected", exp_q.size());
      end_with_failure();
    end
  end

endmodule

`default_nettype wire

//--- dma_noc_req.f
+incdir+source
source/dma_pkg.sv
source/dma_req_table.sv
source/dma_noc_req_gen.sv
source/dma_local_reader.sv
source/dma_flit_out.sv
source/dma_noc_req_top.sv
dv/dma_noc_req_assert.sv
dv/dma_noc_req_tb.sv

//--- Makefile
# Verilator build and run of the DMA request path testbench

VERILATOR ?= verilator
TOP       ?= dma_noc_req_tb
RTL_TOP   ?= dma_noc_req_top
FLIST     ?= dma_noc_req.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_STR  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -F -q "$(PASS_STR)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
